// File: design/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0]  reg_idx_t;  // Register file index
    typedef logic [31:0] word_t;     // Data and address word

    // One fetched word, three ways to read it
    typedef union packed {
        struct packed {
            logic [5:0] opcode;  // Always OP_RTYPE here
            reg_idx_t   rs;      // First source
            reg_idx_t   rt;      // Second source
            reg_idx_t   rd;      // Destination
            logic [4:0] shamt;   // Fixed shift amount
            logic [5:0] funct;   // Selects the R-type operation
        } r;
        struct packed {
            logic [5:0]  opcode;
            reg_idx_t    rs;     // Base or first source
            reg_idx_t    rt;     // Destination or store data
            logic [15:0] imm;    // Offset or operand
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;  // Word index inside the 256 MB region
        } j;
    } instr_t;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;  // Decoded further by funct
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;  // Zero-extended operand
    localparam logic [5:0] OP_ORI   = 6'b001101;  // Zero-extended operand
    localparam logic [5:0] OP_XORI  = 6'b001110;  // Zero-extended operand
    localparam logic [5:0] OP_LUI   = 6'b001111;  // Operand moved to upper half
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LBU   = 6'b100100;
    localparam logic [5:0] OP_LHU   = 6'b100101;
    localparam logic [5:0] OP_LWU   = 6'b100111;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // R-type funct codes
    localparam logic [5:0] FN_SLL  = 6'b000000;  // Shift by shamt
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;  // Shift by rs
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam reg_idx_t RA_IDX = 5'd31;  // Link register for JAL

endpackage

// File: design/control_pkg.sv
package control_pkg;

    localparam int CONTROL_SIZE = 18;  // Width of the decoded word

    typedef logic [CONTROL_SIZE-1:0] control_t;

    // Bit positions inside control_t
    localparam int REG_WRITE = 0;   // Writes the register file
    localparam int BRANCH    = 1;   // Conditional branch taken on equal
    localparam int UNSIGNED  = 2;   // No overflow trap, zero-fill on loads
    localparam int MEM_READ  = 3;   // Load
    localparam int MEM_WRITE = 4;   // Store
    localparam int MASK_1    = 5;   // Sub-word access
    localparam int MASK_2    = 6;   // Byte access, with MASK_1
    localparam int REG_DST   = 7;   // Destination is rd, else rt
    localparam int SHIFT_SRC = 8;   // Shift amount from shamt
    localparam int ALU_SRC   = 9;   // Second operand is the immediate
    localparam int ALU_OP0   = 10;  // ALU operation LSB
    localparam int ALU_OP1   = 11;
    localparam int ALU_OP2   = 12;  // ALU operation MSB
    localparam int MEM_2_REG = 13;  // Write-back from memory
    localparam int J_RET_DST = 14;  // Destination forced to the link register
    localparam int EQ_OR_NE  = 15;  // Branch compare selects equality sense
    localparam int JUMP_SRC  = 16;  // Target from the index field, else rs
    localparam int JUMP_B    = 17;  // Unconditional jump

    typedef logic [2:0] alu_op_t;

    // ALU operation codes carried in ALU_OP2..ALU_OP0
    localparam alu_op_t ALU_SUB   = 3'b000;  // Also the branch compare
    localparam alu_op_t ALU_ADD   = 3'b001;  // Address and add
    localparam alu_op_t ALU_SLT   = 3'b010;
    localparam alu_op_t ALU_AND   = 3'b011;
    localparam alu_op_t ALU_OR    = 3'b100;
    localparam alu_op_t ALU_XOR   = 3'b101;
    localparam alu_op_t ALU_LUI   = 3'b110;
    localparam alu_op_t ALU_FUNCT = 3'b111;  // R-type, ALU decodes funct itself

endpackage

// File: design/general_control.sv
module general_control (
    input  logic                  enable,  // ID slot holds a real instruction
    input  logic [5:0]            opcode,  // Primary opcode field
    input  logic [5:0]            func,    // Funct field, only meaningful for R-type
    output control_pkg::control_t control  // Decoded word toward ID/EX
);

    control_pkg::alu_op_t alu_op;  // Packed into the word after decode

    always_comb begin
        control = '0;                    // Bubble unless something matches
        alu_op  = control_pkg::ALU_SUB;  // Zero code keeps a bubble all-zero
        if (enable) begin
            casez ({opcode, func})
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SLL},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SRL},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SRA},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SLLV},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SRLV},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SRAV},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_ADDU},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SUBU},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_AND},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_OR},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_XOR},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_NOR},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SLT},
                {isa_pkg::OP_RTYPE, isa_pkg::FN_SLTU}: begin
                    control[control_pkg::REG_WRITE] = 1'b1;
                    control[control_pkg::REG_DST]   = 1'b1;  // Result to rd
                    control[control_pkg::SHIFT_SRC] = func inside {isa_pkg::FN_SLL,
                        isa_pkg::FN_SRL, isa_pkg::FN_SRA};   // Fixed shifts use shamt
                    control[control_pkg::UNSIGNED]  = func inside {isa_pkg::FN_ADDU,
                        isa_pkg::FN_SUBU, isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR,
                        isa_pkg::FN_NOR, isa_pkg::FN_SLTU};
                    alu_op = control_pkg::ALU_FUNCT;         // ALU reads funct
                end
                {isa_pkg::OP_RTYPE, isa_pkg::FN_JALR}: begin
                    control[control_pkg::JUMP_B]    = 1'b1;  // Target from rs
                    control[control_pkg::J_RET_DST] = 1'b1;  // Link into r31
                    control[control_pkg::REG_DST]   = 1'b1;
                    control[control_pkg::REG_WRITE] = 1'b1;
                end
                {isa_pkg::OP_RTYPE, isa_pkg::FN_JR}: begin
                    control[control_pkg::JUMP_B] = 1'b1;     // No link
                end
                {isa_pkg::OP_LB, 6'b??????}, {isa_pkg::OP_LH, 6'b??????},
                {isa_pkg::OP_LW, 6'b??????}, {isa_pkg::OP_LBU, 6'b??????},
                {isa_pkg::OP_LHU, 6'b??????}, {isa_pkg::OP_LWU, 6'b??????}: begin
                    control[control_pkg::REG_WRITE] = 1'b1;
                    control[control_pkg::MEM_READ]  = 1'b1;
                    control[control_pkg::MEM_2_REG] = 1'b1;  // Write back load data
                    control[control_pkg::ALU_SRC]   = 1'b1;  // Base plus offset
                    alu_op = control_pkg::ALU_ADD;
                end
                {isa_pkg::OP_SB, 6'b??????}, {isa_pkg::OP_SH, 6'b??????},
                {isa_pkg::OP_SW, 6'b??????}: begin
                    control[control_pkg::MEM_WRITE] = 1'b1;
                    control[control_pkg::ALU_SRC]   = 1'b1;  // Base plus offset
                    alu_op = control_pkg::ALU_ADD;
                end
                {isa_pkg::OP_ADDI, 6'b??????}, {isa_pkg::OP_ADDIU, 6'b??????},
                {isa_pkg::OP_SLTI, 6'b??????}, {isa_pkg::OP_SLTIU, 6'b??????},
                {isa_pkg::OP_ANDI, 6'b??????}, {isa_pkg::OP_ORI, 6'b??????},
                {isa_pkg::OP_XORI, 6'b??????}, {isa_pkg::OP_LUI, 6'b??????}: begin
                    control[control_pkg::REG_WRITE] = 1'b1;
                    control[control_pkg::ALU_SRC]   = 1'b1;  // Immediate operand
                    control[control_pkg::UNSIGNED]  = (opcode != isa_pkg::OP_ADDI) &&
                                                      (opcode != isa_pkg::OP_SLTI);
                    case (opcode)
                        isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU: alu_op = control_pkg::ALU_SLT;
                        isa_pkg::OP_ANDI: alu_op = control_pkg::ALU_AND;
                        isa_pkg::OP_ORI:  alu_op = control_pkg::ALU_OR;
                        isa_pkg::OP_XORI: alu_op = control_pkg::ALU_XOR;
                        isa_pkg::OP_LUI:  alu_op = control_pkg::ALU_LUI;  // Pass operand
                        default:          alu_op = control_pkg::ALU_ADD;  // ADDI, ADDIU
                    endcase
                end
                {isa_pkg::OP_BEQ, 6'b??????}: begin
                    control[control_pkg::BRANCH]   = 1'b1;
                    control[control_pkg::EQ_OR_NE] = 1'b1;
                    alu_op = control_pkg::ALU_SUB;           // Compare by subtraction
                end
                {isa_pkg::OP_BNE, 6'b??????}: begin
                    control[control_pkg::EQ_OR_NE] = 1'b1;   // Same compare, BRANCH clear
                    alu_op = control_pkg::ALU_SUB;
                end
                {isa_pkg::OP_J, 6'b??????}, {isa_pkg::OP_JAL, 6'b??????}: begin
                    control[control_pkg::JUMP_B]    = 1'b1;
                    control[control_pkg::JUMP_SRC]  = 1'b1;  // Target from index
                    control[control_pkg::J_RET_DST] = (opcode == isa_pkg::OP_JAL);
                    control[control_pkg::REG_WRITE] = (opcode == isa_pkg::OP_JAL);
                end
                default: ;                                   // Unsupported stays zero
            endcase
            // Access width from opcode[1:0], 00 byte, 01 half, 11 word
            if (control[control_pkg::MEM_READ] || control[control_pkg::MEM_WRITE]) begin
                control[control_pkg::MASK_1] = (opcode[1:0] != 2'b11);
                control[control_pkg::MASK_2] = (opcode[1:0] == 2'b00);
            end
            if (control[control_pkg::MEM_READ])
                control[control_pkg::UNSIGNED] = opcode[2];  // LBU, LHU, LWU zero-fill
        end
        control[control_pkg::ALU_OP2] = alu_op[2];
        control[control_pkg::ALU_OP1] = alu_op[1];
        control[control_pkg::ALU_OP0] = alu_op[0];
    end

endmodule

// File: design/immediate_unit.sv
module immediate_unit (
    input  isa_pkg::instr_t instr,          // Word in ID, read as I and J format
    input  isa_pkg::word_t  pc_plus4,       // Address of the next sequential word
    output isa_pkg::word_t  imm_ext,        // Operand for the ALU
    output isa_pkg::word_t  branch_target,  // Taken target for BEQ/BNE
    output isa_pkg::word_t  jump_target     // Target for J/JAL
);

    logic [15:0]    imm;       // Raw immediate from the I view
    logic [25:0]    index;     // Raw index from the J view
    isa_pkg::word_t imm_sign;  // Sign-extended immediate
    isa_pkg::word_t offset;    // Branch offset in bytes

    assign imm      = instr.i.imm;
    assign index    = instr.j.index;
    assign imm_sign = {{16{imm[15]}}, imm};
    assign offset   = {imm_sign[29:0], 2'b00};  // Word offset times four

    // Logic immediates zero-fill, LUI moves to the upper half
    always_comb begin
        case (instr.i.opcode)
            isa_pkg::OP_ANDI,
            isa_pkg::OP_ORI,
            isa_pkg::OP_XORI: imm_ext = {16'h0000, imm};
            isa_pkg::OP_LUI:  imm_ext = {imm, 16'h0000};
            default:          imm_ext = imm_sign;  // Arithmetic, loads, stores, branches
        endcase
    end

    assign branch_target = pc_plus4 + offset;  // Only adder in the stage

    // Region bits from PC+4, then the word index
    assign jump_target = {pc_plus4[31:28], index, 2'b00};

endmodule

// File: design/id_ex_register.sv
module id_ex_register (
    input  logic                  clk,
    input  logic                  reset,             // Synchronous, clears all fields
    input  logic                  flush,             // Turns this cycle into a bubble
    input  control_pkg::control_t control,           // From the main decoder
    input  isa_pkg::word_t        imm_ext,
    input  isa_pkg::word_t        branch_target,
    input  isa_pkg::word_t        jump_target,
    input  isa_pkg::reg_idx_t     rs,
    input  isa_pkg::reg_idx_t     rt,
    input  isa_pkg::reg_idx_t     rd,
    output control_pkg::control_t ex_control,        // Zero means no side effects
    output isa_pkg::word_t        ex_imm,
    output isa_pkg::word_t        ex_branch_target,
    output isa_pkg::word_t        ex_jump_target,
    output isa_pkg::reg_idx_t     ex_rs,
    output isa_pkg::reg_idx_t     ex_rt,
    output isa_pkg::reg_idx_t     ex_dst             // Write-back register index
);

    isa_pkg::reg_idx_t dst;  // Destination picked in ID

    // Link register wins over rd, rd over rt
    always_comb begin
        if (control[control_pkg::J_RET_DST])
            dst = isa_pkg::RA_IDX;
        else if (control[control_pkg::REG_DST])
            dst = rd;
        else
            dst = rt;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_control       <= '0;
            ex_imm           <= '0;
            ex_branch_target <= '0;
            ex_jump_target   <= '0;
            ex_rs            <= '0;
            ex_rt            <= '0;
            ex_dst           <= '0;
        end else begin
            ex_control       <= flush ? '0 : control;  // Bubble kills only control
            ex_imm           <= imm_ext;               // Data loads regardless
            ex_branch_target <= branch_target;
            ex_jump_target   <= jump_target;
            ex_rs            <= rs;                    // Kept for forwarding in EX
            ex_rt            <= rt;
            ex_dst           <= dst;
        end
    end

endmodule

// File: design/decode_stage.sv
module decode_stage (
    input  logic                  clk,
    input  logic                  reset,             // Synchronous, active high
    input  logic                  valid,             // Instruction in ID is real
    input  logic                  flush,             // External bubble request
    input  isa_pkg::instr_t       instr,             // Fetched word
    input  isa_pkg::word_t        pc_plus4,          // PC of the word plus four
    output control_pkg::control_t ex_control,
    output isa_pkg::word_t        ex_imm,
    output isa_pkg::word_t        ex_branch_target,
    output isa_pkg::word_t        ex_jump_target,
    output isa_pkg::reg_idx_t     ex_rs,
    output isa_pkg::reg_idx_t     ex_rt,
    output isa_pkg::reg_idx_t     ex_dst
);

    control_pkg::control_t control;        // Decoded this cycle
    isa_pkg::word_t        imm_ext;
    isa_pkg::word_t        branch_target;
    isa_pkg::word_t        jump_target;

    general_control general_control_inst (
        .enable  (valid),                  // Invalid slot decodes as a bubble
        .opcode  (instr.r.opcode),
        .func    (instr.r.funct),
        .control (control)
    );

    immediate_unit immediate_unit_inst (
        .instr         (instr),
        .pc_plus4      (pc_plus4),
        .imm_ext       (imm_ext),
        .branch_target (branch_target),
        .jump_target   (jump_target)
    );

    id_ex_register id_ex_register_inst (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .control          (control),
        .imm_ext          (imm_ext),
        .branch_target    (branch_target),
        .jump_target      (jump_target),
        .rs               (instr.r.rs),    // Register fields via R view
        .rt               (instr.r.rt),
        .rd               (instr.r.rd),
        .ex_control       (ex_control),
        .ex_imm           (ex_imm),
        .ex_branch_target (ex_branch_target),
        .ex_jump_target   (ex_jump_target),
        .ex_rs            (ex_rs),
        .ex_rt            (ex_rt),
        .ex_dst           (ex_dst)
    );

endmodule

// File: tests/decode_stage_assertions.sv
module decode_stage_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input control_pkg::control_t ex_control
);

    int unsigned fail_count = 0;  // Failed checks so far

    // Reset or flush leaves a bubble in EX
    bubble_after_clear: assert property (@(posedge clk)
        (reset || flush) |=> (ex_control == '0))
        else begin
            $error("ex_control not zero after reset or flush");
            fail_count++;
        end

    // A load and a store never share one slot
    no_read_and_write: assert property (@(posedge clk)
        !(ex_control[control_pkg::MEM_READ] && ex_control[control_pkg::MEM_WRITE]))
        else begin
            $error("MEM_READ and MEM_WRITE both set");
            fail_count++;
        end

    jump_not_branch: assert property (@(posedge clk)
        ex_control[control_pkg::JUMP_B] |-> !ex_control[control_pkg::BRANCH])
        else begin
            $error("JUMP_B set together with BRANCH");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_assertions decode_stage_assertions_inst (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .ex_control (ex_control)
);

// File: tests/decode_stage_tb.sv
module decode_stage_tb;

    logic                  clk;
    logic                  reset;
    logic                  valid;
    logic                  flush;
    isa_pkg::instr_t       instr;
    isa_pkg::word_t        pc_plus4;
    control_pkg::control_t ex_control;
    isa_pkg::word_t        ex_imm;
    isa_pkg::word_t        ex_branch_target;
    isa_pkg::word_t        ex_jump_target;
    isa_pkg::reg_idx_t     ex_rs;
    isa_pkg::reg_idx_t     ex_rt;
    isa_pkg::reg_idx_t     ex_dst;

    // One row per instruction, 64 rows of room
    isa_pkg::word_t        tab_instr [0:63];
    isa_pkg::word_t        tab_pc    [0:63];
    logic                  tab_valid [0:63];
    logic                  tab_flush [0:63];
    control_pkg::control_t exp_ctrl  [0:63];  // After flush and valid
    isa_pkg::word_t        exp_imm   [0:63];
    isa_pkg::word_t        exp_br    [0:63];
    isa_pkg::word_t        exp_jt    [0:63];
    isa_pkg::reg_idx_t     exp_rs    [0:63];
    isa_pkg::reg_idx_t     exp_rt    [0:63];
    isa_pkg::reg_idx_t     exp_dst   [0:63];

    int          n_entries = 0;
    int          cur_entry = -1;     // Row under check, -1 for reset
    int          cycles    = 0;      // Rising edges seen
    logic [31:0] rng       = 32'd96; // xorshift state

    decode_stage decode_stage_inst (
        .clk              (clk),
        .reset            (reset),
        .valid            (valid),
        .flush            (flush),
        .instr            (instr),
        .pc_plus4         (pc_plus4),
        .ex_control       (ex_control),
        .ex_imm           (ex_imm),
        .ex_branch_target (ex_branch_target),
        .ex_jump_target   (ex_jump_target),
        .ex_rs            (ex_rs),
        .ex_rt            (ex_rt),
        .ex_dst           (ex_dst)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // Period 8
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "decode_stage_tb stopped at first error");
    endtask

    task automatic check_control(input string name, input control_pkg::control_t exp,
                                 input control_pkg::control_t act);
        if (act !== exp) begin
            $display("Mismatch %s entry %0d: expected %h, actual %h", name, cur_entry, exp, act);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            $display("Mismatch %s entry %0d: expected %h, actual %h", name, cur_entry, exp, act);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input isa_pkg::reg_idx_t exp,
                             input isa_pkg::reg_idx_t act);
        if (act !== exp) begin
            $display("Mismatch %s entry %0d: expected %h, actual %h", name, cur_entry, exp, act);
            stop_run();
        end
    endtask

    // Fills random fields, then derives every expected output from the ISA rules
    task automatic add_entry(input logic [5:0] op, input logic [5:0] fn,
                             input control_pkg::control_t ctrl, input logic v = 1'b1,
                             input logic f = 1'b0, input logic neg = 1'b0);
        isa_pkg::word_t        raw;
        isa_pkg::word_t        pc;
        isa_pkg::word_t        sext;
        control_pkg::control_t dec;
        rng = xorshift(rng);
        raw = {op, rng[25:0]};                  // Random rs, rt, rd, imm or index
        if (op == isa_pkg::OP_RTYPE)
            raw[5:0] = fn;
        if (neg)
            raw[15] = 1'b1;                     // Backward branch offset
        rng  = xorshift(rng);
        pc   = {rng[31:2], 2'b00};              // Word aligned
        sext = {{16{raw[15]}}, raw[15:0]};
        dec  = v ? ctrl : '0;                   // Empty slot decodes to a bubble
        tab_instr[n_entries] = raw;
        tab_pc[n_entries]    = pc;
        tab_valid[n_entries] = v;
        tab_flush[n_entries] = f;
        exp_ctrl[n_entries]  = f ? '0 : dec;    // Flush kills control only
        if (op == isa_pkg::OP_ANDI || op == isa_pkg::OP_ORI || op == isa_pkg::OP_XORI)
            exp_imm[n_entries] = {16'h0000, raw[15:0]};
        else if (op == isa_pkg::OP_LUI)
            exp_imm[n_entries] = {raw[15:0], 16'h0000};
        else
            exp_imm[n_entries] = sext;
        exp_br[n_entries] = pc + (sext << 2);
        exp_jt[n_entries] = {pc[31:28], raw[25:0], 2'b00};
        exp_rs[n_entries] = raw[25:21];
        exp_rt[n_entries] = raw[20:16];
        if (dec[control_pkg::J_RET_DST])
            exp_dst[n_entries] = 5'd31;         // Link register
        else if (dec[control_pkg::REG_DST])
            exp_dst[n_entries] = raw[15:11];    // rd
        else
            exp_dst[n_entries] = raw[20:16];    // rt
        n_entries++;
    endtask

    task automatic build_table();
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SLL,  18'h01D81);  // Shifts by shamt
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SRL,  18'h01D81);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SRA,  18'h01D81);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SLLV, 18'h01C81);  // Shifts by rs
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SRLV, 18'h01C81);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SRAV, 18'h01C81);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_JR,   18'h20000);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_JALR, 18'h24081);  // Links into r31
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_ADDU, 18'h01C85);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SUBU, 18'h01C85);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_AND,  18'h01C85);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_OR,   18'h01C85);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_XOR,  18'h01C85);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_NOR,  18'h01C85);
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SLT,  18'h01C81);  // Signed compare
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_SLTU, 18'h01C85);
        add_entry(isa_pkg::OP_LB,    6'd0, 18'h02669);              // Byte mask
        add_entry(isa_pkg::OP_LH,    6'd0, 18'h02629);              // Half mask
        add_entry(isa_pkg::OP_LW,    6'd0, 18'h02609);
        add_entry(isa_pkg::OP_LBU,   6'd0, 18'h0266D);              // Zero-fill loads
        add_entry(isa_pkg::OP_LHU,   6'd0, 18'h0262D);
        add_entry(isa_pkg::OP_LWU,   6'd0, 18'h0260D);
        add_entry(isa_pkg::OP_SB,    6'd0, 18'h00670);
        add_entry(isa_pkg::OP_SH,    6'd0, 18'h00630);
        add_entry(isa_pkg::OP_SW,    6'd0, 18'h00610);
        add_entry(isa_pkg::OP_ADDI,  6'd0, 18'h00601);
        add_entry(isa_pkg::OP_ADDIU, 6'd0, 18'h00605);
        add_entry(isa_pkg::OP_SLTI,  6'd0, 18'h00A01);
        add_entry(isa_pkg::OP_SLTIU, 6'd0, 18'h00A05);
        add_entry(isa_pkg::OP_ANDI,  6'd0, 18'h00E05);
        add_entry(isa_pkg::OP_ORI,   6'd0, 18'h01205);
        add_entry(isa_pkg::OP_XORI,  6'd0, 18'h01605);
        add_entry(isa_pkg::OP_LUI,   6'd0, 18'h01A05);              // Upper-half operand
        add_entry(isa_pkg::OP_BEQ,   6'd0, 18'h08002, 1'b1, 1'b0, 1'b1);  // Negative offset
        add_entry(isa_pkg::OP_BNE,   6'd0, 18'h08000, 1'b1, 1'b0, 1'b1);
        add_entry(isa_pkg::OP_BEQ,   6'd0, 18'h08002);
        add_entry(isa_pkg::OP_BNE,   6'd0, 18'h08000);
        add_entry(isa_pkg::OP_J,     6'd0, 18'h30000);
        add_entry(isa_pkg::OP_JAL,   6'd0, 18'h34001);              // rd forced to 31
        add_entry(6'b111111,         6'd0, 18'h00000);              // Unknown opcode
        add_entry(isa_pkg::OP_RTYPE, 6'b001100, 18'h00000);         // Unknown funct
        add_entry(isa_pkg::OP_ADDI,  6'd0, 18'h00601, 1'b0);        // Empty slot
        add_entry(isa_pkg::OP_LW,    6'd0, 18'h02609, 1'b1, 1'b1);  // Flushed load
        add_entry(isa_pkg::OP_RTYPE, isa_pkg::FN_ADDU, 18'h01C85);  // Back to normal
        add_entry(isa_pkg::OP_JAL,   6'd0, 18'h34001, 1'b1, 1'b1);  // Flushed, dst still 31
        add_entry(isa_pkg::OP_SW,    6'd0, 18'h00610);
    endtask

    task automatic drive_entry(input int k);
        instr    = tab_instr[k];
        pc_plus4 = tab_pc[k];
        valid    = tab_valid[k];
        flush    = tab_flush[k];
    endtask

    task automatic check_entry(input int k);
        cur_entry = k;
        if (decode_stage_inst.decode_stage_assertions_inst.fail_count != 0) begin
            $display("A bound assertion failed before entry %0d was checked", k);
            stop_run();
        end
        check_control("ex_control", exp_ctrl[k], ex_control);
        check_word("ex_imm", exp_imm[k], ex_imm);
        check_word("ex_branch_target", exp_br[k], ex_branch_target);
        check_word("ex_jump_target", exp_jt[k], ex_jump_target);
        check_reg("ex_rs", exp_rs[k], ex_rs);
        check_reg("ex_rt", exp_rt[k], ex_rt);
        check_reg("ex_dst", exp_dst[k], ex_dst);
    endtask

    task automatic check_reset_state();
        cur_entry = -1;
        check_control("ex_control", '0, ex_control);
        check_word("ex_imm", '0, ex_imm);
        check_word("ex_branch_target", '0, ex_branch_target);
        check_word("ex_jump_target", '0, ex_jump_target);
        check_reg("ex_rs", '0, ex_rs);
        check_reg("ex_rt", '0, ex_rt);
        check_reg("ex_dst", '0, ex_dst);
    endtask

    // Run limit from table length plus margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > n_entries + 20) begin
            $display("Timeout after %0d cycles, the table never finished", cycles);
            stop_run();
        end
    end

    initial begin
        reset    = 1'b1;
        valid    = 1'b0;
        flush    = 1'b0;
        instr    = '0;
        pc_plus4 = '0;
        build_table();
        repeat (4) @(negedge clk);     // Four rising edges in reset
        check_reset_state();
        reset = 1'b0;
        drive_entry(0);
        for (int k = 1; k <= n_entries; k++) begin
            @(negedge clk);            // Outputs settled since the rising edge
            check_entry(k - 1);
            if (k < n_entries)
                drive_entry(k);
        end
        if (decode_stage_inst.decode_stage_assertions_inst.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("A bound assertion failed near the end of the run");
            stop_run();
        end
    end

endmodule

// File: files.f
design/isa_pkg.sv
design/control_pkg.sv
design/general_control.sv
design/immediate_unit.sv
design/id_ex_register.sv
design/decode_stage.sv
tests/decode_stage_assertions.sv
tests/decode_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f \
    --top-module decode_stage_tb -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past an assertion error so the testbench reports it
./obj_dir/decode_stage_sim +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
